//--- lc3b_mem.f
+incdir+rtl
rtl/lc3b_types.sv
rtl/l1_cache.sv
rtl/arbiter.sv
rtl/lc3b_mem.sv
tests/lc3b_mem_tb.sv

//--- rtl/arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module arbiter
    import lc3b_types::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  lc3b_pmem_req i_icache_req,  // instruction cache line request.
    input  lc3b_pmem_req i_dcache_req,  // data cache line request.
    output logic         o_icache_resp,
    output logic         o_dcache_resp,
    output lc3b_mem_data o_rdata,       // shared by both caches.
    output lc3b_pmem_req o_pmem_req,
    input  logic         i_pmem_resp,
    input  lc3b_mem_data i_pmem_rdata
);

    arb_owner_t owner_q;       // current grant.
    logic       icache_wants;
    logic       dcache_wants;

    assign icache_wants = i_icache_req.read || i_icache_req.write;
    assign dcache_wants = i_dcache_req.read || i_dcache_req.write;

    // --------------------
    // grant register
    // --------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            owner_q <= NONE;
        end else begin
            case (owner_q)
                NONE: begin
                    if (dcache_wants) begin
                        owner_q <= DCACHE; // data side first.
                    end else if (icache_wants) begin
                        owner_q <= ICACHE;
                    end
                end
                ICACHE, DCACHE: begin
                    if (i_pmem_resp) begin
                        owner_q <= NONE; // release after transfer.
                    end
                end
                default: owner_q <= NONE;
            endcase
        end
    end

    // only the owner's request goes out.
    always_comb begin
        case (owner_q)
            ICACHE:  o_pmem_req = i_icache_req;
            DCACHE:  o_pmem_req = i_dcache_req;
            default: o_pmem_req = '0;
        endcase
    end

    assign o_icache_resp = (owner_q == ICACHE) && i_pmem_resp; // owner only.
    assign o_dcache_resp = (owner_q == DCACHE) && i_pmem_resp;
    assign o_rdata       = i_pmem_rdata; // broadcast.

    // --------------------
    // checks
    // --------------------
    // every memory resp reaches exactly one cache.
    a_one_resp: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pmem_resp |-> (o_icache_resp ^ o_dcache_resp))
        else $error("pmem resp not routed to exactly one cache");

    // granted request must hold until memory answers.
    a_grant_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (owner_q != NONE && !i_pmem_resp) |=> $stable(o_pmem_req))
        else $error("pmem request changed before resp");

endmodule

`default_nettype wire

//--- rtl/l1_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_macros.svh"

module l1_cache
    import lc3b_types::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  lc3b_cpu_req  i_cpu_req,    // held until o_resp.
    output logic         o_resp,
    output lc3b_word     o_rdata,
    output lc3b_pmem_req o_pmem_req,   // line request to arbiter.
    input  logic         i_pmem_resp,
    input  lc3b_mem_data i_pmem_rdata
);

    // --------------------
    // storage
    // --------------------
    lc3b_mem_data                  data_q  [`LC3B_L1_LINES]; // line data.
    logic [`LC3B_TAG_W-1:0]        tag_q   [`LC3B_L1_LINES]; // stored tags.
    logic [`LC3B_L1_LINES-1:0]     valid_q;                  // line holds data.
    logic [`LC3B_L1_LINES-1:0]     dirty_q;                  // line differs from memory.

    l1_state_t                     state_q;  // control fsm.
    logic                          resp_q;   // one cycle cpu resp.
    lc3b_word                      rdata_q;  // word returned with resp.

    // --------------------
    // address decode
    // --------------------
    logic [`LC3B_TAG_W-1:0]        req_tag;
    logic [`LC3B_INDEX_W-1:0]      req_index;
    logic [`LC3B_OFFSET_W-2:0]     word_sel;  // word within line.
    logic [6:0]                    bit_base;  // word start bit in line.

    logic                          req_any;   // read or write present.
    logic                          accept;    // request sampled this edge.
    logic                          hit;
    logic                          hit_accept;
    logic                          fill_done;
    lc3b_mem_data                  cur_line;
    lc3b_mem_data                  merged_line;

    assign req_tag   = i_cpu_req.address[`LC3B_WORD_W-1 -: `LC3B_TAG_W];
    assign req_index = i_cpu_req.address[`LC3B_OFFSET_W +: `LC3B_INDEX_W];
    assign word_sel  = i_cpu_req.address[`LC3B_OFFSET_W-1:1];
    assign bit_base  = {word_sel, 4'b0000}; // 16 bits per word.

    assign req_any    = i_cpu_req.read || i_cpu_req.write;
    assign accept     = req_any && (state_q == IDLE) && !resp_q; // skip the resp cycle.
    assign hit        = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign hit_accept = accept && hit;
    assign fill_done  = (state_q == FILL) && i_pmem_resp;
    assign cur_line   = data_q[req_index];

    // byte merge of write data into the indexed line.
    always_comb begin
        merged_line = cur_line;
        if (i_cpu_req.write) begin
            if (i_cpu_req.byte_enable[0]) begin
                merged_line[bit_base +: 8] = i_cpu_req.wdata[7:0];   // low byte.
            end
            if (i_cpu_req.byte_enable[1]) begin
                merged_line[bit_base + 7'd8 +: 8] = i_cpu_req.wdata[15:8]; // high byte.
            end
        end
    end

    // --------------------
    // control fsm
    // --------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            resp_q  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_q <= 1'b0; // pulse only.
            case (state_q)
                IDLE: begin
                    if (hit_accept) begin
                        resp_q <= 1'b1; // answer next cycle.
                        if (i_cpu_req.write) begin
                            dirty_q[req_index] <= 1'b1;
                        end
                    end else if (accept) begin
                        // on a miss evict a dirty victim first.
                        if (valid_q[req_index] && dirty_q[req_index]) begin
                            state_q <= WRITEBACK;
                        end else begin
                            state_q <= FILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (i_pmem_resp) begin
                        dirty_q[req_index] <= 1'b0; // memory now current.
                        state_q            <= FILL;
                    end
                end
                FILL: begin
                    if (i_pmem_resp) begin
                        valid_q[req_index] <= 1'b1;
                        dirty_q[req_index] <= 1'b0;
                        state_q            <= IDLE; // retry as hit.
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // --------------------
    // arrays and read data
    // --------------------
    always_ff @(posedge clk) begin
        if (hit_accept) begin
            rdata_q <= merged_line[bit_base +: 16]; // read word or merged write word.
            if (i_cpu_req.write) begin
                data_q[req_index] <= merged_line;
            end
        end
        if (fill_done) begin
            data_q[req_index] <= i_pmem_rdata; // new line from memory.
            tag_q[req_index]  <= req_tag;
        end
    end

    // line request from fsm state.
    always_comb begin
        o_pmem_req = '0;
        case (state_q)
            WRITEBACK: begin
                o_pmem_req.write   = 1'b1;
                o_pmem_req.address = {tag_q[req_index], req_index, 4'b0000}; // victim line.
                o_pmem_req.wdata   = cur_line;
            end
            FILL: begin
                o_pmem_req.read    = 1'b1;
                o_pmem_req.address = {req_tag, req_index, 4'b0000}; // requested line.
            end
            default: o_pmem_req = '0;
        endcase
    end

    assign o_resp  = resp_q;
    assign o_rdata = rdata_q;

    // --------------------
    // checks
    // --------------------
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_cpu_req.read && i_cpu_req.write))
        else $error("cpu read and write together");

    a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (state_q != IDLE) |-> $stable(i_cpu_req))
        else $error("cpu request changed during miss");

endmodule

`default_nettype wire

//--- rtl/lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// --------------------
// memory geometry
// --------------------
`define LC3B_WORD_W   16   // cpu word width.
`define LC3B_LINE_W   128  // one cache line.
`define LC3B_L1_LINES 8    // lines per l1 cache.

// tag + index + offset = word width.
`define LC3B_OFFSET_W 4    // byte offset in line.
`define LC3B_INDEX_W  3    // line select.
`define LC3B_TAG_W    9    // upper address bits.

`endif

//--- rtl/lc3b_mem.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_mem
    import lc3b_types::*;
(
    input  logic         clk,
    input  logic         i_rst_n,

    // instruction port.
    input  lc3b_cpu_req  i_instr_req,
    output logic         o_instr_resp,
    output lc3b_word     o_instr_rdata,

    // data port.
    input  lc3b_cpu_req  i_data_req,
    output logic         o_data_resp,
    output lc3b_word     o_data_rdata,

    // physical memory port.
    output lc3b_pmem_req o_pmem_req,
    input  logic         i_pmem_resp,
    input  lc3b_mem_data i_pmem_rdata
);

    // --------------------
    // cache to arbiter
    // --------------------
    lc3b_pmem_req icache_pmem_req;  // instruction line request.
    lc3b_pmem_req dcache_pmem_req;  // data line request.
    logic         icache_pmem_resp;
    logic         dcache_pmem_resp;
    lc3b_mem_data arb_rdata;        // line data to both caches.

    l1_cache i_cache (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_cpu_req    (i_instr_req),
        .o_resp       (o_instr_resp),
        .o_rdata      (o_instr_rdata),
        .o_pmem_req   (icache_pmem_req),
        .i_pmem_resp  (icache_pmem_resp),
        .i_pmem_rdata (arb_rdata)
    );

    l1_cache d_cache (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_cpu_req    (i_data_req),
        .o_resp       (o_data_resp),
        .o_rdata      (o_data_rdata),
        .o_pmem_req   (dcache_pmem_req),
        .i_pmem_resp  (dcache_pmem_resp),
        .i_pmem_rdata (arb_rdata)
    );

    arbiter arbiter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_icache_req  (icache_pmem_req),
        .i_dcache_req  (dcache_pmem_req),
        .o_icache_resp (icache_pmem_resp),
        .o_dcache_resp (dcache_pmem_resp),
        .o_rdata       (arb_rdata),
        .o_pmem_req    (o_pmem_req),
        .i_pmem_resp   (i_pmem_resp),
        .i_pmem_rdata  (i_pmem_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/lc3b_types.sv
`default_nettype none

package lc3b_types;

    `include "lc3b_macros.svh"

    // --------------------
    // basic data types
    // --------------------
    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;      // address or data word.
    typedef logic [`LC3B_LINE_W-1:0] lc3b_mem_data;  // full cache line.
    typedef logic [1:0]              lc3b_mem_wmask; // bit 0 is the low byte.

    // cpu side request held until resp.
    typedef struct packed {
        logic          read;        // word read.
        logic          write;       // word write.
        lc3b_mem_wmask byte_enable; // bytes to write.
        lc3b_word      address;     // byte address.
        lc3b_word      wdata;       // write word.
    } lc3b_cpu_req;

    // line request toward physical memory.
    typedef struct packed {
        logic         read;    // line fill.
        logic         write;   // line write-back.
        lc3b_word     address; // line aligned.
        lc3b_mem_data wdata;   // victim line.
    } lc3b_pmem_req;

    // --------------------
    // control encodings
    // --------------------
    typedef enum logic [1:0] {IDLE, WRITEBACK, FILL} l1_state_t;
    typedef enum logic [1:0] {NONE, ICACHE, DCACHE} arb_owner_t;

endpackage

`default_nettype wire

//--- tests/lc3b_mem_input.txt
# port(I/D) op(R/W) byte_enable addr wdata expected_rdata pair
# pair 1 issues the line together with the next one, expected_rdata is checked on reads only
I R 3 0040 0000 5a1a 0
I R 3 0040 0000 5a1a 0
D R 3 0102 0000 5b58 0
D R 3 0102 0000 5b58 0
D W 3 0104 beef 0000 0
D R 3 0104 0000 beef 0
D W 1 0106 1234 0000 0
D R 3 0106 0000 5b34 0
D W 2 0108 abcd 0000 0
D R 3 0108 0000 ab52 0
D R 3 0182 0000 5bd8 0
D R 3 0104 0000 beef 0
D R 3 0106 0000 5b34 0
D R 3 0108 0000 ab52 0
D W 3 0204 cafe 0000 0
D R 3 0204 0000 cafe 0
D R 3 0206 0000 585c 0
D R 3 0104 0000 beef 0
D R 3 0204 0000 cafe 0
I R 3 0350 0000 590a 1
D R 3 0460 0000 5e3a 0
D W 3 0022 0f0f 0000 1
I R 3 0042 0000 5a18 0
I R 3 00a0 0000 5afa 1
D R 3 00a2 0000 5af8 0
I R 3 0022 0000 0f0f 1
D R 3 0022 0000 0f0f 0
I R 3 0350 0000 590a 1
D R 3 0460 0000 5e3a 0

//--- tests/lc3b_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lc3b_macros.svh"

module lc3b_mem_tb
    import lc3b_types::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam     INPUT_FILE   = "tests/lc3b_mem_input.txt";
    localparam     SEED         = 32'hda66c0e2;

    // one line of the stimulus file.
    typedef struct packed {
        logic       is_data;    // D port, else I port.
        logic       is_write;
        logic [1:0] be;
        lc3b_word   addr;
        lc3b_word   wdata;
        lc3b_word   exp_rdata;  // checked on reads.
        logic       paired;     // issue with the next line.
    } op_entry_t;

    logic         clk;
    logic         rst_n;
    lc3b_cpu_req  instr_req;
    logic         instr_resp;
    lc3b_word     instr_rdata;
    lc3b_cpu_req  data_req;
    logic         data_resp;
    lc3b_word     data_rdata;
    lc3b_pmem_req pmem_req;
    logic         pmem_resp;
    lc3b_mem_data pmem_rdata;

    op_entry_t    ops [$];
    logic         ops_loaded;
    lc3b_mem_data mem_lines [lc3b_word];                       // written lines only.
    logic                   shadow_valid [2][`LC3B_L1_LINES];  // expected cache contents.
    logic [`LC3B_TAG_W-1:0] shadow_tag   [2][`LC3B_L1_LINES];

    lc3b_mem i_lc3b_mem (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_instr_req   (instr_req),
        .o_instr_resp  (instr_resp),
        .o_instr_rdata (instr_rdata),
        .i_data_req    (data_req),
        .o_data_resp   (data_resp),
        .o_data_rdata  (data_rdata),
        .o_pmem_req    (pmem_req),
        .i_pmem_resp   (pmem_resp),
        .i_pmem_rdata  (pmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // helpers
    // --------------------
    task automatic stop_failed();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    // untouched lines hold their byte address xor 5a5a per word.
    function automatic lc3b_mem_data read_line(input lc3b_word line_addr);
        lc3b_mem_data line;
        lc3b_word     byte_addr;
        if (mem_lines.exists(line_addr)) begin
            line = mem_lines[line_addr];
        end else begin
            for (int w = 0; w < 8; w++) begin
                byte_addr          = line_addr + 16'(2 * w);
                line[w*16 +: 16]   = byte_addr ^ 16'h5a5a;
            end
        end
        return line;
    endfunction

    task automatic drive_port(input logic is_data, input lc3b_cpu_req req);
        if (is_data) begin
            data_req = req;
        end else begin
            instr_req = req;
        end
    endtask

    // issue one access, wait for resp, check data and hit latency.
    task automatic run_op(input op_entry_t op);
        lc3b_cpu_req            req;
        int                     cycles;
        logic                   resp;
        logic                   hit_expected;
        logic [`LC3B_INDEX_W-1:0] index;
        logic [`LC3B_TAG_W-1:0]   tag;
        lc3b_word               rdata;
        string                  port_name;
        index        = op.addr[`LC3B_OFFSET_W +: `LC3B_INDEX_W];
        tag          = op.addr[`LC3B_WORD_W-1 -: `LC3B_TAG_W];
        hit_expected = shadow_valid[op.is_data][index] && (shadow_tag[op.is_data][index] == tag);
        if (op.is_data) begin
            port_name = "o_data";
        end else begin
            port_name = "o_instr";
        end
        req.read        = !op.is_write;
        req.write       = op.is_write;
        req.byte_enable = op.be;
        req.address     = op.addr;
        req.wdata       = op.wdata;
        drive_port(op.is_data, req);
        cycles = 0;
        resp   = 1'b0;
        while (!resp) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            resp   = op.is_data ? data_resp : instr_resp;
        end
        rdata = op.is_data ? data_rdata : instr_rdata;
        if (!op.is_write) begin
            check_value({port_name, "_rdata"}, op.exp_rdata, rdata);
        end
        if (hit_expected) begin
            check_value({port_name, "_resp hit latency"}, 1, cycles);
        end else begin
            check_value({port_name, "_resp miss slower than hit"}, 1, cycles > 1);
        end
        shadow_valid[op.is_data][index] = 1'b1;
        shadow_tag[op.is_data][index]   = tag;
        @(posedge clk);
        #2;
        drive_port(op.is_data, '0); // drop in the cycle after resp.
    endtask

    // --------------------
    // physical memory model
    // --------------------
    initial begin : pmem_model
        lc3b_pmem_req req;
        int           delay;
        int unsigned  seed_dummy;
        seed_dummy = $urandom(SEED);
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        @(posedge clk);
        #2;
        forever begin
            if (pmem_req.read || pmem_req.write) begin
                req   = pmem_req;
                delay = 2 + ($urandom % 5); // 2 to 6 cycles.
                repeat (delay) @(posedge clk);
                #2;
                if (req.write) begin
                    mem_lines[req.address] = req.wdata; // whole line.
                end else begin
                    pmem_rdata = read_line(req.address);
                end
                pmem_resp = 1'b1;
                @(posedge clk);
                #2;
                pmem_resp = 1'b0;
            end else begin
                @(posedge clk);
                #2;
            end
        end
    end

    // pmem port must never carry both commands.
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("o_pmem_req read and write", 0, pmem_req.read && pmem_req.write);
        end
    end

    initial begin : watchdog
        wait (ops_loaded);
        repeat (ops.size() * 40 + 100) @(posedge clk);
        $display("timeout: the operations did not complete within %0d cycles",
                 ops.size() * 40 + 100);
        stop_failed();
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin : main
        int          fd;
        int          n;
        int          c;
        int          idx;
        logic        done;
        logic [7:0]  port_c;
        logic [7:0]  op_c;
        int unsigned be_v;
        int unsigned addr_v;
        int unsigned wdata_v;
        int unsigned exp_v;
        int unsigned pair_v;
        op_entry_t   entry;
        rst_n      = 1'b0;
        instr_req  = '0;
        data_req   = '0;
        ops_loaded = 1'b0;
        for (int p = 0; p < 2; p++) begin
            for (int l = 0; l < `LC3B_L1_LINES; l++) begin
                shadow_valid[p][l] = 1'b0;
                shadow_tag[p][l]   = '0;
            end
        end

        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", INPUT_FILE);
            stop_failed();
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", port_c);
            if (n != 1) begin
                done = 1'b1;
            end else if (port_c == "#") begin
                c = $fgetc(fd);                 // skip comment line.
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                n = $fscanf(fd, " %c %h %h %h %h %d", op_c, be_v, addr_v, wdata_v, exp_v,
                            pair_v);
                if (n != 6 || (port_c != "I" && port_c != "D")) begin
                    $display("malformed line %0d in stimulus file", ops.size() + 1);
                    stop_failed();
                end
                entry.is_data   = (port_c == "D");
                entry.is_write  = (op_c == "W");
                entry.be        = be_v[1:0];
                entry.addr      = addr_v[15:0];
                entry.wdata     = wdata_v[15:0];
                entry.exp_rdata = exp_v[15:0];
                entry.paired    = pair_v[0];
                ops.push_back(entry);
            end
        end
        $fclose(fd);
        ops_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // quiet interface after reset.
        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("o_instr_resp", 0, instr_resp);
            check_value("o_data_resp", 0, data_resp);
            check_value("o_pmem_req.read", 0, pmem_req.read);
            check_value("o_pmem_req.write", 0, pmem_req.write);
        end
        #1;

        idx = 0;
        while (idx < ops.size()) begin
            if (ops[idx].paired && idx + 1 < ops.size()) begin
                if (ops[idx].is_data == ops[idx + 1].is_data) begin
                    $display("paired operations at line %0d use the same port", idx + 1);
                    stop_failed();
                end
                fork
                    run_op(ops[idx]);
                    run_op(ops[idx + 1]);
                join
                idx = idx + 2;
            end else begin
                run_op(ops[idx]);
                idx = idx + 1;
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
